/* files.f */
logic/mem_sys_pkg.sv
logic/mem_bus_if.sv
logic/fetch_port.sv
logic/load_store_port.sv
logic/bus_arbiter.sv
logic/data_memory.sv
logic/mem_sys_top.sv
verif/mem_sys_tb.sv

/* logic/bus_arbiter.sv */
`timescale 1ns/10ps

module bus_arbiter (
  input  logic      clk,
  input  logic      rst,
  mem_bus_if.slave  fetch_bus,
  mem_bus_if.slave  lsu_bus,
  mem_bus_if.master mem_bus
);
  import mem_sys_pkg::*;

  logic busy_q;
  logic grant_lsu_q;
  logic sel_lsu;
  logic mem_accept;

  // pick a port while idle, ties follow DATA_PORT_FIRST
  always_comb begin
    if (lsu_bus.req_valid && fetch_bus.req_valid) begin
      sel_lsu = DATA_PORT_FIRST;
    end else begin
      sel_lsu = lsu_bus.req_valid;
    end
  end

  // request path is combinational from the chosen port
  assign mem_bus.req_valid = !busy_q && (sel_lsu ? lsu_bus.req_valid : fetch_bus.req_valid);
  assign mem_bus.we        = sel_lsu ? lsu_bus.we    : fetch_bus.we;
  assign mem_bus.addr      = sel_lsu ? lsu_bus.addr  : fetch_bus.addr;
  assign mem_bus.wstrb     = sel_lsu ? lsu_bus.wstrb : fetch_bus.wstrb;
  assign mem_bus.wdata     = sel_lsu ? lsu_bus.wdata : fetch_bus.wdata;

  assign mem_accept = mem_bus.req_valid && mem_bus.req_ready;

  // only the chosen port sees ready, and nobody while busy
  assign fetch_bus.req_ready = !busy_q && !sel_lsu && mem_bus.req_ready;
  assign lsu_bus.req_ready   = !busy_q && sel_lsu && mem_bus.req_ready;

  // grant held from acceptance until the response
  always_ff @(posedge clk) begin
    if (rst) begin
      busy_q      <= 1'b0;
      grant_lsu_q <= 1'b0;
    end else if (mem_accept) begin
      busy_q      <= 1'b1;
      grant_lsu_q <= sel_lsu;
    end else if (busy_q && mem_bus.rsp_valid) begin
      busy_q <= 1'b0;
    end
  end

  // response goes back to the granted port only
  assign fetch_bus.rsp_valid = busy_q && !grant_lsu_q && mem_bus.rsp_valid;
  assign lsu_bus.rsp_valid   = busy_q && grant_lsu_q && mem_bus.rsp_valid;
  assign fetch_bus.rdata     = mem_bus.rdata;
  assign lsu_bus.rdata       = mem_bus.rdata;

endmodule

/* logic/data_memory.sv */
`timescale 1ns/10ps

module data_memory (
  input  logic     clk,
  mem_bus_if.slave bus
);
  import mem_sys_pkg::*;

  data_t                 mem [MEM_WORDS];
  logic [WORD_IDX_W-1:0] idx;
  logic                  rsp_q;
  data_t                 rdata_q;

  // never stalls
  assign bus.req_ready = 1'b1;

  // upper address bits wrap onto the same word index
  assign idx = bus.addr[OFFS_W +: WORD_IDX_W];

  // read sees the word before this access writes it
  always_ff @(posedge clk) begin
    if (bus.req_valid) begin
      rdata_q <= mem[idx];
      for (int b = 0; b < STRB_W; b++) begin
        if (bus.we && bus.wstrb[b]) mem[idx][8*b +: 8] <= bus.wdata[8*b +: 8];
      end
    end
  end

  // one response pulse per accepted request
  always_ff @(posedge clk) begin
    rsp_q <= bus.req_valid;
  end

  assign bus.rsp_valid = rsp_q;
  assign bus.rdata     = rdata_q;

endmodule

/* logic/fetch_port.sv */
`timescale 1ns/10ps

module fetch_port (
  input  logic                clk,
  input  logic                rst,
  input  logic                valid_i,
  output logic                ready_o,
  input  mem_sys_pkg::addr_t  addr_i,
  output logic                done_o,
  output mem_sys_pkg::inst_t  inst_o,
  mem_bus_if.master           bus
);
  import mem_sys_pkg::*;

  logic  busy_q;
  logic  pend_q;
  logic  done_q;
  logic  accept;
  addr_t addr_q;
  inst_t inst_q;

  assign ready_o = !busy_q;
  assign accept  = valid_i && ready_o;

  // read only, so no write lanes
  assign bus.req_valid = pend_q;
  assign bus.we        = 1'b0;
  assign bus.addr      = addr_q;
  assign bus.wstrb     = '0;
  assign bus.wdata     = '0;

  always_ff @(posedge clk) begin
    if (rst) begin
      busy_q <= 1'b0;
      pend_q <= 1'b0;
      done_q <= 1'b0;
    end else begin
      done_q <= bus.rsp_valid;
      if (accept) begin
        busy_q <= 1'b1;
        pend_q <= 1'b1;
      end else begin
        if (pend_q && bus.req_ready) pend_q <= 1'b0;
        if (bus.rsp_valid) busy_q <= 1'b0;
      end
    end
  end

  // address bit 2 picks the upper instruction of the word
  always_ff @(posedge clk) begin
    if (accept) addr_q <= addr_i;
    if (bus.rsp_valid) inst_q <= addr_q[2] ? bus.rdata[DATA_W-1:INST_W] : bus.rdata[INST_W-1:0];
  end

  assign done_o = done_q;
  assign inst_o = inst_q;

endmodule

/* logic/load_store_port.sv */
`timescale 1ns/10ps

module load_store_port (
  input  logic                clk,
  input  logic                rst,
  input  logic                valid_i,
  output logic                ready_o,
  input  logic                we_i,
  input  mem_sys_pkg::addr_t  addr_i,
  input  mem_sys_pkg::size_e  size_i,
  input  logic                unsigned_i,
  input  mem_sys_pkg::data_t  wdata_i,
  output logic                done_o,
  output mem_sys_pkg::data_t  rdata_o,
  mem_bus_if.master           bus
);
  import mem_sys_pkg::*;

  logic              busy_q;
  logic              pend_q;
  logic              done_q;
  logic              accept;
  logic              we_q;
  logic              unsigned_q;
  addr_t             addr_q;
  size_e             size_q;
  strb_t             strb_q;
  data_t             wdata_q;
  data_t             rdata_q;
  logic [OFFS_W-1:0] offs_in;
  strb_t             base_strb;
  strb_t             strb_in;
  data_t             lane_in;
  data_t             shifted;
  data_t             ext;

  assign ready_o = !busy_q;
  assign accept  = valid_i && ready_o;
  assign offs_in = addr_i[OFFS_W-1:0];

  // strobe covers size bytes starting at the byte offset
  always_comb begin
    unique case (size_i)
      SIZE_B:  base_strb = strb_t'(8'h01);
      SIZE_H:  base_strb = strb_t'(8'h03);
      SIZE_W:  base_strb = strb_t'(8'h0f);
      default: base_strb = strb_t'(8'hff);
    endcase
  end

  assign strb_in = base_strb << offs_in;
  assign lane_in = wdata_i << {offs_in, 3'b000};

  // load path: align to byte 0, then extend as writeback does
  assign shifted = bus.rdata >> {addr_q[OFFS_W-1:0], 3'b000};

  always_comb begin
    unique case (size_q)
      SIZE_B: ext = unsigned_q ? {{(DATA_W-8){1'b0}}, shifted[7:0]}
                               : {{(DATA_W-8){shifted[7]}}, shifted[7:0]};
      SIZE_H: ext = unsigned_q ? {{(DATA_W-16){1'b0}}, shifted[15:0]}
                               : {{(DATA_W-16){shifted[15]}}, shifted[15:0]};
      SIZE_W: ext = unsigned_q ? {{(DATA_W-32){1'b0}}, shifted[31:0]}
                               : {{(DATA_W-32){shifted[31]}}, shifted[31:0]};
      default: ext = shifted;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      busy_q <= 1'b0;
      pend_q <= 1'b0;
      done_q <= 1'b0;
    end else begin
      done_q <= bus.rsp_valid;
      if (accept) begin
        busy_q <= 1'b1;
        pend_q <= 1'b1;
      end else begin
        if (pend_q && bus.req_ready) pend_q <= 1'b0;
        if (bus.rsp_valid) busy_q <= 1'b0;
      end
    end
  end

  // loads go out with an empty strobe
  always_ff @(posedge clk) begin
    if (accept) begin
      we_q       <= we_i;
      addr_q     <= addr_i;
      size_q     <= size_i;
      unsigned_q <= unsigned_i;
      strb_q     <= we_i ? strb_in : '0;
      wdata_q    <= lane_in;
    end
    if (bus.rsp_valid) rdata_q <= ext;
  end

  assign bus.req_valid = pend_q;
  assign bus.we        = we_q;
  assign bus.addr      = addr_q;
  assign bus.wstrb     = strb_q;
  assign bus.wdata     = wdata_q;

  assign done_o  = done_q;
  assign rdata_o = rdata_q;

endmodule

/* logic/mem_bus_if.sv */
`timescale 1ns/10ps

interface mem_bus_if;
  import mem_sys_pkg::*;

  // request direction
  logic  req_valid;
  logic  req_ready;
  logic  we;
  addr_t addr;
  strb_t wstrb;
  data_t wdata;

  // response direction, one pulse per accepted request
  logic  rsp_valid;
  data_t rdata;

  modport master (
    output req_valid, we, addr, wstrb, wdata,
    input  req_ready, rsp_valid, rdata
  );

  modport slave (
    input  req_valid, we, addr, wstrb, wdata,
    output req_ready, rsp_valid, rdata
  );

endinterface

/* logic/mem_sys_pkg.sv */
package mem_sys_pkg;

  // bus and address widths
  localparam int ADDR_W = 32;
  localparam int DATA_W = 64;
  localparam int INST_W = 32;
  localparam int STRB_W = DATA_W / 8;

  // 256 words of 64 bits, 2 KiB in total
  localparam int MEM_WORDS = 256;
  localparam int WORD_IDX_W = $clog2(MEM_WORDS);

  // byte offset inside one bus word
  localparam int OFFS_W = $clog2(STRB_W);

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [DATA_W-1:0] data_t;
  typedef logic [INST_W-1:0] inst_t;
  typedef logic [STRB_W-1:0] strb_t;

  // access size of a load or store
  typedef enum logic [1:0] {
    SIZE_B = 2'd0,
    SIZE_H = 2'd1,
    SIZE_W = 2'd2,
    SIZE_D = 2'd3
  } size_e;

  // data port wins a tie, as the memory stage must not starve
  localparam bit DATA_PORT_FIRST = 1'b1;

endpackage

/* logic/mem_sys_top.sv */
`timescale 1ns/10ps

module mem_sys_top (
  input  logic                clk,
  input  logic                rst,

  // instruction fetch side
  input  logic                fetch_valid_i,
  output logic                fetch_ready_o,
  input  mem_sys_pkg::addr_t  fetch_addr_i,
  output logic                fetch_done_o,
  output mem_sys_pkg::inst_t  fetch_inst_o,

  // load/store side
  input  logic                lsu_valid_i,
  output logic                lsu_ready_o,
  input  logic                lsu_we_i,
  input  mem_sys_pkg::addr_t  lsu_addr_i,
  input  mem_sys_pkg::size_e  lsu_size_i,
  input  logic                lsu_unsigned_i,
  input  mem_sys_pkg::data_t  lsu_wdata_i,
  output logic                lsu_done_o,
  output mem_sys_pkg::data_t  lsu_rdata_o
);

  mem_bus_if fetch_bus ();
  mem_bus_if lsu_bus ();
  mem_bus_if mem_bus ();

  fetch_port u_fetch_port (
    .clk     (clk),
    .rst     (rst),
    .valid_i (fetch_valid_i),
    .ready_o (fetch_ready_o),
    .addr_i  (fetch_addr_i),
    .done_o  (fetch_done_o),
    .inst_o  (fetch_inst_o),
    .bus     (fetch_bus.master)
  );

  load_store_port u_load_store_port (
    .clk        (clk),
    .rst        (rst),
    .valid_i    (lsu_valid_i),
    .ready_o    (lsu_ready_o),
    .we_i       (lsu_we_i),
    .addr_i     (lsu_addr_i),
    .size_i     (lsu_size_i),
    .unsigned_i (lsu_unsigned_i),
    .wdata_i    (lsu_wdata_i),
    .done_o     (lsu_done_o),
    .rdata_o    (lsu_rdata_o),
    .bus        (lsu_bus.master)
  );

  // two requesters share the one memory bus
  bus_arbiter u_bus_arbiter (
    .clk       (clk),
    .rst       (rst),
    .fetch_bus (fetch_bus.slave),
    .lsu_bus   (lsu_bus.slave),
    .mem_bus   (mem_bus.master)
  );

  data_memory u_data_memory (
    .clk (clk),
    .bus (mem_bus.slave)
  );

endmodule

/* run.sh */
#!/usr/bin/env bash
# build the testbench with Verilator, run it, and look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f files.f --top-module mem_sys_tb -o mem_sys_sim \
  && ./obj_dir/mem_sys_sim | tee /dev/stderr | grep -qx "PASS: all tests" \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

/* verif/mem_sys_tb.sv */
`timescale 1ns/10ps

module mem_sys_tb;
  import mem_sys_pkg::*;

  localparam int SPACE   = MEM_WORDS * STRB_W;
  localparam int SPACE_W = $clog2(SPACE);
  localparam int TMO     = 50;

  logic  clk;
  logic  rst;
  logic  fetch_valid_i;
  logic  fetch_ready_o;
  addr_t fetch_addr_i;
  logic  fetch_done_o;
  inst_t fetch_inst_o;
  logic  lsu_valid_i;
  logic  lsu_ready_o;
  logic  lsu_we_i;
  addr_t lsu_addr_i;
  size_e lsu_size_i;
  logic  lsu_unsigned_i;
  data_t lsu_wdata_i;
  logic  lsu_done_o;
  data_t lsu_rdata_o;

  integer seed;
  int     value_errs;
  int     other_errs;

  // reference model with one byte and one valid flag per address
  logic [7:0] model_mem [SPACE];
  bit         model_ok  [SPACE];

  mem_sys_top dut (
    .clk            (clk),
    .rst            (rst),
    .fetch_valid_i  (fetch_valid_i),
    .fetch_ready_o  (fetch_ready_o),
    .fetch_addr_i   (fetch_addr_i),
    .fetch_done_o   (fetch_done_o),
    .fetch_inst_o   (fetch_inst_o),
    .lsu_valid_i    (lsu_valid_i),
    .lsu_ready_o    (lsu_ready_o),
    .lsu_we_i       (lsu_we_i),
    .lsu_addr_i     (lsu_addr_i),
    .lsu_size_i     (lsu_size_i),
    .lsu_unsigned_i (lsu_unsigned_i),
    .lsu_wdata_i    (lsu_wdata_i),
    .lsu_done_o     (lsu_done_o),
    .lsu_rdata_o    (lsu_rdata_o)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  function automatic int size_bytes(size_e s);
    return 1 << int'(s);
  endfunction

  function automatic addr_t random_addr(int n);
    return addr_t'($random(seed) & (SPACE - 1) & ~(n - 1));
  endfunction

  function automatic bit model_valid(addr_t a, int n);
    bit ok;
    ok = 1'b1;
    for (int i = 0; i < n; i++) ok = ok && model_ok[a[SPACE_W-1:0] + SPACE_W'(i)];
    return ok;
  endfunction

  // bytes from the offset up, then sign or zero fill
  function automatic data_t model_load(addr_t a, size_e s, bit uns);
    data_t v;
    int    n;
    v = '0;
    n = size_bytes(s);
    for (int i = 0; i < n; i++) v[8*i +: 8] = model_mem[a[SPACE_W-1:0] + SPACE_W'(i)];
    if (!uns && n < 8 && v[8*n-1]) v = v | ~((64'd1 << (8*n)) - 64'd1);
    return v;
  endfunction

  function automatic inst_t model_fetch(addr_t a);
    inst_t v;
    for (int i = 0; i < 4; i++) v[8*i +: 8] = model_mem[{a[SPACE_W-1:2], 2'b00} + SPACE_W'(i)];
    return v;
  endfunction

  task automatic model_store(input addr_t a, input size_e s, input data_t d);
    for (int i = 0; i < size_bytes(s); i++) begin
      model_mem[a[SPACE_W-1:0] + SPACE_W'(i)] = d[8*i +: 8];
      model_ok[a[SPACE_W-1:0] + SPACE_W'(i)]  = 1'b1;
    end
  endtask

  task automatic check_inst(input string name, input inst_t exp, input inst_t act);
    if (act !== exp) begin
      $display("FAILED %s expected %h actual %h", name, exp, act);
      value_errs++;
    end
  endtask

  task automatic check_data(input string name, input data_t exp, input data_t act);
    if (act !== exp) begin
      $display("FAILED %s expected %h actual %h", name, exp, act);
      value_errs++;
    end
  endtask

  task automatic check_ready(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("FAILED %s expected %b actual %b", name, exp, act);
      value_errs++;
    end
  endtask

  // one fetch, one load/store, or both in the same cycle
  task automatic issue(input string name, input bit do_f, input addr_t fa, input bit do_l,
                       input bit we, input addr_t a, input size_e s, input bit uns,
                       input data_t wd);
    data_t exp;
    inst_t exp_inst;
    bit    chk;
    bit    chk_inst;
    bit    f_seen;
    bit    l_seen;
    int    cnt;
    cnt = 0;
    while (!(fetch_ready_o && lsu_ready_o) && cnt < TMO) begin
      @(negedge clk);
      cnt++;
    end
    if (!(fetch_ready_o && lsu_ready_o)) begin
      $display("%s: ports never returned to ready", name);
      other_errs++;
    end
    fetch_valid_i  = do_f;
    fetch_addr_i   = fa;
    lsu_valid_i    = do_l;
    lsu_we_i       = we;
    lsu_addr_i     = a;
    lsu_size_i     = s;
    lsu_unsigned_i = uns;
    lsu_wdata_i    = wd;
    @(negedge clk);
    fetch_valid_i = 1'b0;
    lsu_valid_i   = 1'b0;
    // accepted on the rising edge just passed
    exp = model_load(a, s, uns);
    chk = do_l && !we && model_valid(a, size_bytes(s));
    // data port wins a tie, so its store lands before the fetch reads
    if (do_l && we) model_store(a, s, wd);
    exp_inst = model_fetch(fa);
    chk_inst = do_f && model_valid({fa[ADDR_W-1:2], 2'b00}, 4);
    // done pulses of the previous access are one cycle wide
    check_ready({name, " fetch done low"}, 1'b0, fetch_done_o);
    check_ready({name, " lsu done low"}, 1'b0, lsu_done_o);
    if (do_f) check_ready({name, " fetch busy"}, 1'b0, fetch_ready_o);
    if (do_l) check_ready({name, " lsu busy"}, 1'b0, lsu_ready_o);
    f_seen = !do_f;
    l_seen = !do_l;
    cnt = 0;
    while (!(f_seen && l_seen) && cnt < TMO) begin
      @(negedge clk);
      cnt++;
      // ready stays low until the own done pulse
      if (!f_seen && !fetch_done_o) begin
        check_ready({name, " fetch busy"}, 1'b0, fetch_ready_o);
      end
      if (!l_seen && !lsu_done_o) begin
        check_ready({name, " lsu busy"}, 1'b0, lsu_ready_o);
      end
      if (fetch_done_o) begin
        if (f_seen) begin
          $display("%s: fetch port gave an extra done pulse", name);
          other_errs++;
        end else if (chk_inst) begin
          check_inst({name, " inst"}, exp_inst, fetch_inst_o);
        end
        f_seen = 1'b1;
      end
      if (lsu_done_o) begin
        if (l_seen) begin
          $display("%s: data port gave an extra done pulse", name);
          other_errs++;
        end else if (chk) begin
          check_data({name, " rdata"}, exp, lsu_rdata_o);
        end
        l_seen = 1'b1;
      end
    end
    if (!f_seen) begin
      $display("%s: fetch port never completed", name);
      other_errs++;
    end
    if (!l_seen) begin
      $display("%s: data port never completed", name);
      other_errs++;
    end
  endtask

  initial begin
    addr_t a;
    addr_t off;
    data_t d;
    int    n;
    int    m;
    bit    we_r;
    bit    uns_r;
    seed           = 32'ha778_aeef;
    value_errs     = 0;
    other_errs     = 0;
    rst            = 1'b1;
    fetch_valid_i  = 1'b0;
    fetch_addr_i   = '0;
    lsu_valid_i    = 1'b0;
    lsu_we_i       = 1'b0;
    lsu_addr_i     = '0;
    lsu_size_i     = SIZE_B;
    lsu_unsigned_i = 1'b0;
    lsu_wdata_i    = '0;
    for (int i = 0; i < SPACE; i++) model_ok[i] = 1'b0;
    repeat (16) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    check_ready("reset fetch ready", 1'b1, fetch_ready_o);
    check_ready("reset lsu ready", 1'b1, lsu_ready_o);
    check_ready("reset fetch done", 1'b0, fetch_done_o);
    check_ready("reset lsu done", 1'b0, lsu_done_o);

    // aligned store, then every smaller load inside it
    for (int s = 0; s < 4; s++) begin
      n = 1 << s;
      repeat (6) begin
        a = random_addr(n);
        d = {$random(seed), $random(seed)};
        issue("store_load", 1'b0, '0, 1'b1, 1'b1, a, size_e'(s), 1'b0, d);
        for (int l = 0; l <= s; l++) begin
          m   = 1 << l;
          off = addr_t'($random(seed) & (n - 1) & ~(m - 1));
          issue("store_load", 1'b0, '0, 1'b1, 1'b0, a + off, size_e'(l), 1'b0, '0);
          issue("store_load", 1'b0, '0, 1'b1, 1'b0, a + off, size_e'(l), 1'b1, '0);
        end
      end
    end

    repeat (8) begin
      a = random_addr(8);
      issue("subword_keep", 1'b0, '0, 1'b1, 1'b1, a, SIZE_D, 1'b0,
            {$random(seed), $random(seed)});
      off = addr_t'($random(seed) & 7);
      issue("subword_keep", 1'b0, '0, 1'b1, 1'b1, a + off, SIZE_B, 1'b0,
            data_t'($random(seed)));
      off = addr_t'($random(seed) & 6);
      issue("subword_keep", 1'b0, '0, 1'b1, 1'b1, a + off, SIZE_H, 1'b0,
            data_t'($random(seed)));
      issue("subword_keep", 1'b0, '0, 1'b1, 1'b0, a, SIZE_D, 1'b0, '0);
    end

    repeat (8) begin
      a = random_addr(8);
      d = {$random(seed), $random(seed)};
      issue("fetch_half", 1'b0, '0, 1'b1, 1'b1, a, SIZE_D, 1'b0, d);
      issue("fetch_half", 1'b1, a, 1'b0, 1'b0, '0, SIZE_B, 1'b0, '0);
      issue("fetch_half", 1'b1, a + 4, 1'b0, 1'b0, '0, SIZE_B, 1'b0, '0);
    end

    // every word known before the mixed traffic
    for (int w = 0; w < MEM_WORDS; w++) begin
      issue("concurrent", 1'b0, '0, 1'b1, 1'b1, addr_t'(w * STRB_W), SIZE_D, 1'b0,
            {$random(seed), $random(seed)});
    end
    repeat (200) begin
      m     = $random(seed) & 3;
      we_r  = 1'($random(seed));
      uns_r = 1'($random(seed));
      issue("concurrent", 1'b1, random_addr(4), 1'b1, we_r, random_addr(1 << m),
            size_e'(m), uns_r, {$random(seed), $random(seed)});
    end

    $display("errors: %0d wrong values, %0d other failures", value_errs, other_errs);
    if (value_errs == 0 && other_errs == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule
